// File: Bender.yml
package:
  name: mem_bridge

sources:
  - verilog/mem_bridge_pkg.sv
  - verilog/ret_if.sv
  - verilog/write_buffer.sv
  - verilog/return_buffer.sv
  - verilog/read_arbiter.sv
  - verilog/mem_bridge.sv
  - target: test
    files:
      - verification/tb_clkgen.sv
      - verification/mem_bridge_props.sv
      - verification/mem_bridge_tb.sv

// File: mem_bridge.f
verilog/mem_bridge_pkg.sv
verilog/ret_if.sv
verilog/write_buffer.sv
verilog/return_buffer.sv
verilog/read_arbiter.sv
verilog/mem_bridge.sv
verification/tb_clkgen.sv
verification/mem_bridge_props.sv
verification/mem_bridge_tb.sv

// File: verification/mem_bridge_props.sv
// ----------------------------------------
// refill bridge protocol properties
// ----------------------------------------
module mem_bridge_props (
    input logic clk,
    input logic rstn,
    input logic rd_addr_ok,
    input logic rd_data_ok,
    input logic rd_rdy,
    input logic mem_ar_valid,
    input logic mem_ar_ready,
    input logic mem_wr_valid,
    input logic wb_full
);
    timeunit 1ns;
    timeprecision 1ps;

    int   fail_cnt = 0;
    logic addr_seen;

    // address accepted and line not yet taken
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            addr_seen <= 1'b0;
        end else if (rd_addr_ok) begin
            addr_seen <= 1'b1;
        end else if (rd_data_ok && rd_rdy) begin
            addr_seen <= 1'b0;
        end
    end

    data_after_addr: assert property (@(posedge clk) disable iff (!rstn)
        $rose(rd_data_ok) |-> addr_seen)
        else begin
            $error("rd_data_ok rose with no address accepted");
            fail_cnt++;
        end

    ar_held: assert property (@(posedge clk) disable iff (!rstn)
        mem_ar_valid && !mem_ar_ready |=> mem_ar_valid)
        else begin
            $error("mem_ar_valid dropped before mem_ar_ready");
            fail_cnt++;
        end

    data_held: assert property (@(posedge clk) disable iff (!rstn)
        rd_data_ok && !rd_rdy |=> rd_data_ok)
        else begin
            $error("rd_data_ok dropped before rd_rdy");
            fail_cnt++;
        end

    reset_quiet: assert property (@(posedge clk)
        !rstn |-> !(rd_addr_ok || rd_data_ok || mem_ar_valid || mem_wr_valid || wb_full))
        else begin
            $error("output active during reset");
            fail_cnt++;
        end

endmodule

bind mem_bridge mem_bridge_props u_props (
    .clk(clk), .rstn(rstn), .rd_addr_ok(rd_addr_ok), .rd_data_ok(rd_data_ok),
    .rd_rdy(rd_rdy), .mem_ar_valid(mem_ar_valid), .mem_ar_ready(mem_ar_ready),
    .mem_wr_valid(mem_wr_valid), .wb_full(wb_full)
);

// File: verification/mem_bridge_tb.sv
// ----------------------------------------
// refill bridge testbench
// ----------------------------------------
module mem_bridge_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int words   = 4;
    localparam int line_w  = 32 * words;
    localparam int n_tests = 6;
    // worst case cycles per test with margin
    localparam int worst_cycles = 416;

    typedef logic [line_w-1:0] line_t;

    logic                  clk;
    logic                  rstn;
    logic                  rd_req, rd_dma, rd_rdy, rd_addr_ok, rd_data_ok;
    mem_bridge_pkg::addr_t rd_addr, wr_addr, mem_ar_addr, mem_wr_addr;
    line_t                 rd_data, wr_data, mem_wr_data;
    logic                  wr_valid, wb_full, mem_wr_valid, mem_wr_ack;
    logic                  mem_ar_valid, mem_ar_ready, mem_r_valid, mem_r_last;
    logic [7:0]            mem_ar_len;
    logic [31:0]           mem_r_data;

    logic [31:0]           seed = 32'ha206;
    int                    checks = 0;
    int                    errors = 0;
    int                    drained = 0;
    logic                  drain_en;
    // lines still owed to memory in write order
    mem_bridge_pkg::addr_t pend_addr [$];
    line_t                 pend_data [$];

    tb_clkgen u_clk (.clk(clk), .rstn(rstn));

    mem_bridge #(.offset_width(2), .wb_depth(4)) u_dut (.*);

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // word i of line a holds a + i
    function automatic line_t mem_line(input mem_bridge_pkg::addr_t a);
        line_t l;
        for (int i = 0; i < words; i++) begin
            l[i*32 +: 32] = a + 32'(i);
        end
        return l;
    endfunction

    task automatic check(input string name, input logic [line_w+31:0] exp,
                         input logic [line_w+31:0] act);
        checks++;
        assert (exp === act) else begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic write_line(input mem_bridge_pkg::addr_t a, input line_t d);
        int idx;
        @(negedge clk);
        while (wb_full) @(negedge clk);
        wr_valid = 1'b1;
        wr_addr  = a;
        wr_data  = d;
        @(negedge clk);
        wr_valid = 1'b0;
        idx = -1;
        foreach (pend_addr[i]) begin
            if (pend_addr[i] == a) idx = i;
        end
        if (idx >= 0) begin
            pend_data[idx] = d;
        end else begin
            pend_addr.push_back(a);
            pend_data.push_back(d);
        end
    endtask

    task automatic read_line(input string name, input mem_bridge_pkg::addr_t a,
                             input logic dma, input logic hit, input line_t exp);
        int    cycles;
        int    hold;
        line_t held;
        hold = int'(next_rand() % 5) + 1;
        @(negedge clk);
        rd_req  = 1'b1;
        rd_addr = a;
        rd_dma  = dma;
        cycles  = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!rd_addr_ok);
        if (hit) check({name, " addr_ok delay"}, 2, cycles);
        @(negedge clk);
        rd_req = 1'b0;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!rd_data_ok);
        if (hit) check({name, " data_ok delay"}, 1, cycles);
        held = rd_data;
        // line must sit still while the l2 is not ready
        repeat (hold) begin
            @(posedge clk);
            check({name, " held line"}, {1'b1, held}, {rd_data_ok, rd_data});
        end
        @(negedge clk);
        rd_rdy = 1'b1;
        @(posedge clk);
        check(name, {1'b1, exp}, {rd_data_ok, rd_data});
        @(negedge clk);
        rd_rdy = 1'b0;
        @(posedge clk);
        check({name, " done"}, 0, rd_data_ok);
    endtask

    initial begin : mem_read_model
        mem_bridge_pkg::addr_t a;
        int                    len;
        mem_ar_ready = 1'b0;
        mem_r_valid  = 1'b0;
        mem_r_last   = 1'b0;
        mem_r_data   = '0;
        forever begin
            @(negedge clk);
            if (mem_ar_valid) begin
                repeat (next_rand() % 4) @(negedge clk);
                a   = mem_ar_addr;
                len = mem_ar_len;
                check("ar_len", words - 1, mem_ar_len);
                mem_ar_ready = 1'b1;
                @(negedge clk);
                mem_ar_ready = 1'b0;
                for (int i = 0; i <= len; i++) begin
                    repeat (next_rand() % 3) @(negedge clk);
                    mem_r_valid = 1'b1;
                    mem_r_data  = a + 32'(i);
                    mem_r_last  = (i == len);
                    @(negedge clk);
                    mem_r_valid = 1'b0;
                    mem_r_last  = 1'b0;
                end
            end
        end
    end

    initial begin : mem_write_model
        mem_wr_ack = 1'b0;
        forever begin
            @(negedge clk);
            if (mem_wr_valid && drain_en) begin
                repeat (next_rand() % 3) @(negedge clk);
                if (pend_addr.size() == 0) begin
                    errors++;
                    $display("drain seen with no line left to write back");
                end else begin
                    check("drain order", {pend_addr[0], pend_data[0]},
                          {mem_wr_addr, mem_wr_data});
                    void'(pend_addr.pop_front());
                    void'(pend_data.pop_front());
                end
                mem_wr_ack = 1'b1;
                @(negedge clk);
                mem_wr_ack = 1'b0;
                drained++;
            end
        end
    end

    initial begin : stimulus
        line_t d;
        rd_req   = 1'b0;
        rd_dma   = 1'b0;
        rd_rdy   = 1'b0;
        rd_addr  = '0;
        wr_valid = 1'b0;
        wr_addr  = '0;
        wr_data  = '0;
        drain_en = 1'b0;
        wait (rstn);
        read_line("miss", 32'h1000, 1'b0, 1'b0, mem_line(32'h1000));
        d = {next_rand(), next_rand(), next_rand(), next_rand()};
        write_line(32'h2000, d);
        read_line("hit", 32'h2000, 1'b0, 1'b1, d);
        read_line("dma", 32'h2000, 1'b1, 1'b0, mem_line(32'h2000));
        // fill the buffer with one rewrite on the way
        write_line(32'h3000, ~d);
        write_line(32'h3000, d ^ {words{32'h5a5a_0f0f}});
        write_line(32'h4000, mem_line(32'h4444));
        @(posedge clk);
        check("not full after rewrite", 0, wb_full);
        write_line(32'h5000, ~mem_line(32'h5000));
        @(posedge clk);
        check("full", 1, wb_full);
        read_line("rewrite hit", 32'h3000, 1'b0, 1'b1, d ^ {words{32'h5a5a_0f0f}});
        drain_en = 1'b1;
        wait (drained == 4);
        @(posedge clk);
        check("drained", 0, {wb_full, mem_wr_valid});
        read_line("after drain", 32'h2000, 1'b0, 1'b0, mem_line(32'h2000));
        $display("checks %0d, errors %0d, property failures %0d",
                 checks, errors, u_dut.u_props.fail_cnt);
        if (errors == 0 && u_dut.u_props.fail_cnt == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        #(n_tests * worst_cycles * 8);
        $display("timeout, the run did not finish in time");
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// File: verification/tb_clkgen.sv
// ----------------------------------------
// testbench clock and reset
// ----------------------------------------
module tb_clkgen #(
    parameter int period       = 8,
    parameter int reset_cycles = 8
) (
    output logic clk,
    output logic rstn
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // release lands on a falling edge
    initial begin
        rstn = 1'b0;
        #(period * reset_cycles) rstn = 1'b1;
    end

endmodule

// File: verilog/mem_bridge.sv
// ----------------------------------------
// l2 to memory refill bridge
// ----------------------------------------
module mem_bridge #(
    parameter int offset_width = 2,
    parameter int wb_depth     = 4
) (
    input  logic                             clk,
    input  logic                             rstn,
    // l2 read side
    input  logic                             rd_req,
    input  logic                             rd_dma,
    input  logic                             rd_rdy,
    input  mem_bridge_pkg::addr_t            rd_addr,
    output logic                             rd_addr_ok,
    output logic                             rd_data_ok,
    output logic [32*(1<<offset_width)-1:0]  rd_data,
    // l2 write side
    input  logic                             wr_valid,
    input  mem_bridge_pkg::addr_t            wr_addr,
    input  logic [32*(1<<offset_width)-1:0]  wr_data,
    output logic                             wb_full,
    // memory read
    output logic                             mem_ar_valid,
    output mem_bridge_pkg::addr_t            mem_ar_addr,
    output logic [7:0]                       mem_ar_len,
    input  logic                             mem_ar_ready,
    input  logic                             mem_r_valid,
    input  logic                             mem_r_last,
    input  logic [31:0]                      mem_r_data,
    // memory write
    output logic                             mem_wr_valid,
    output mem_bridge_pkg::addr_t            mem_wr_addr,
    output logic [32*(1<<offset_width)-1:0]  mem_wr_data,
    input  logic                             mem_wr_ack
);
    localparam int line_w = 32 * (1 << offset_width);

    mem_bridge_pkg::addr_t query_addr;
    logic                  query_ok;
    logic [line_w-1:0]     query_data;

    ret_if #(.offset_width(offset_width)) u_ret ();

    write_buffer #(.offset_width(offset_width), .wb_depth(wb_depth)) u_wb (
        .clk(clk), .rstn(rstn),
        .wr_valid(wr_valid), .wr_addr(wr_addr), .wr_data(wr_data), .full(wb_full),
        .query_addr(query_addr), .query_ok(query_ok), .query_data(query_data),
        .mem_wr_valid(mem_wr_valid), .mem_wr_addr(mem_wr_addr),
        .mem_wr_data(mem_wr_data), .mem_wr_ack(mem_wr_ack)
    );

    read_arbiter #(.offset_width(offset_width)) u_arb (
        .clk(clk), .rstn(rstn),
        .l2_req(rd_req), .l2_dma(rd_dma), .l2_rdy(rd_rdy), .l2_addr(rd_addr),
        .l2_addr_ok(rd_addr_ok), .l2_data_ok(rd_data_ok), .l2_data(rd_data),
        .query_addr(query_addr), .query_ok(query_ok), .query_data(query_data),
        .ret(u_ret.arb)
    );

    return_buffer #(.offset_width(offset_width)) u_rb (
        .clk(clk), .rstn(rstn), .ret(u_ret.rb),
        .mem_ar_valid(mem_ar_valid), .mem_ar_addr(mem_ar_addr), .mem_ar_len(mem_ar_len),
        .mem_ar_ready(mem_ar_ready), .mem_r_valid(mem_r_valid),
        .mem_r_data(mem_r_data), .mem_r_last(mem_r_last)
    );

endmodule

// File: verilog/mem_bridge_pkg.sv
// ----------------------------------------
// refill bridge shared types
// ----------------------------------------
package mem_bridge_pkg;

    // line-aligned physical address
    typedef logic [31:0] addr_t;

    // read arbiter states
    typedef enum logic [2:0] {
        arb_idle   = 3'd0,
        arb_wrt_ar = 3'd1,
        arb_wrt_r  = 3'd2,
        arb_ret_ar = 3'd3,
        arb_ret_r  = 3'd4
    } arb_state_e;

    // return buffer states
    typedef enum logic [1:0] {
        rb_idle  = 2'd0,
        rb_addr  = 2'd1,
        rb_beats = 2'd2,
        rb_hold  = 2'd3
    } rb_state_e;

endpackage

// File: verilog/read_arbiter.sv
// ----------------------------------------
// l2 read arbiter
// ----------------------------------------
module read_arbiter #(
    parameter int offset_width = 2
) (
    input  logic                             clk,
    input  logic                             rstn,
    input  logic                             l2_req,
    input  logic                             l2_dma,
    input  logic                             l2_rdy,
    input  mem_bridge_pkg::addr_t            l2_addr,
    output logic                             l2_addr_ok,
    output logic                             l2_data_ok,
    output logic [32*(1<<offset_width)-1:0]  l2_data,
    output mem_bridge_pkg::addr_t            query_addr,
    input  logic                             query_ok,
    input  logic [32*(1<<offset_width)-1:0]  query_data,
    ret_if.arb                               ret
);
    localparam int line_w = 32 * (1 << offset_width);

    mem_bridge_pkg::arb_state_e state;
    mem_bridge_pkg::arb_state_e next;
    logic [line_w-1:0]          hit_line;

    assign query_addr = l2_addr;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= mem_bridge_pkg::arb_idle;
        end else begin
            state <= next;
        end
    end

    always_comb begin
        next = state;
        case (state)
            mem_bridge_pkg::arb_idle: begin
                // dma always goes out to memory
                if (l2_req && !l2_dma && query_ok) begin
                    next = mem_bridge_pkg::arb_wrt_ar;
                end else if (l2_req) begin
                    next = mem_bridge_pkg::arb_ret_ar;
                end
            end
            mem_bridge_pkg::arb_wrt_ar: next = mem_bridge_pkg::arb_wrt_r;
            mem_bridge_pkg::arb_wrt_r: begin
                if (l2_rdy) begin
                    next = mem_bridge_pkg::arb_idle;
                end
            end
            mem_bridge_pkg::arb_ret_ar: begin
                if (ret.addr_ok) begin
                    next = mem_bridge_pkg::arb_ret_r;
                end
            end
            mem_bridge_pkg::arb_ret_r: begin
                if (l2_rdy && ret.data_ok) begin
                    next = mem_bridge_pkg::arb_idle;
                end
            end
            default: next = mem_bridge_pkg::arb_idle;
        endcase
    end

    // hit line captured while the query is live
    always_ff @(posedge clk) begin
        if (state == mem_bridge_pkg::arb_idle && l2_req && query_ok) begin
            hit_line <= query_data;
        end
    end

    assign ret.req  = (state == mem_bridge_pkg::arb_ret_ar);
    assign ret.addr = l2_addr;
    assign ret.rlen = 8'((1 << offset_width) - 1);
    assign ret.rdy  = l2_rdy;

    always_comb begin
        l2_addr_ok = 1'b0;
        l2_data_ok = 1'b0;
        l2_data    = '0;
        case (state)
            mem_bridge_pkg::arb_wrt_ar: l2_addr_ok = 1'b1;
            mem_bridge_pkg::arb_wrt_r: begin
                l2_data_ok = 1'b1;
                l2_data    = hit_line;
            end
            mem_bridge_pkg::arb_ret_ar: l2_addr_ok = ret.addr_ok;
            mem_bridge_pkg::arb_ret_r: begin
                l2_data_ok = ret.data_ok;
                l2_data    = ret.data;
            end
            default: ;
        endcase
    end

endmodule

// File: verilog/ret_if.sv
// ----------------------------------------
// arbiter to return buffer link
// ----------------------------------------
interface ret_if #(
    parameter int offset_width = 2
) ();
    localparam int line_w = 32 * (1 << offset_width);

    // request side from the arbiter
    logic                  req;
    mem_bridge_pkg::addr_t addr;
    logic [7:0]            rlen;
    logic                  rdy;

    // response side from the return buffer
    logic                  addr_ok;
    logic                  data_ok;
    logic [line_w-1:0]     data;

    modport arb (output req, addr, rlen, rdy, input addr_ok, data_ok, data);
    modport rb (input req, addr, rlen, rdy, output addr_ok, data_ok, data);

endinterface

// File: verilog/return_buffer.sv
// ----------------------------------------
// burst read return buffer
// ----------------------------------------
module return_buffer #(
    parameter int offset_width = 2
) (
    input  logic                  clk,
    input  logic                  rstn,
    ret_if.rb                     ret,
    output logic                  mem_ar_valid,
    output mem_bridge_pkg::addr_t mem_ar_addr,
    output logic [7:0]            mem_ar_len,
    input  logic                  mem_ar_ready,
    input  logic                  mem_r_valid,
    input  logic [31:0]           mem_r_data,
    input  logic                  mem_r_last
);
    localparam int line_w = 32 * (1 << offset_width);

    mem_bridge_pkg::rb_state_e state;
    mem_bridge_pkg::addr_t     addr_q;
    logic [7:0]                len_q;
    logic [offset_width-1:0]   beat_cnt;
    logic [line_w-1:0]         line_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state    <= mem_bridge_pkg::rb_idle;
            beat_cnt <= '0;
        end else begin
            case (state)
                mem_bridge_pkg::rb_idle: begin
                    if (ret.req) begin
                        state <= mem_bridge_pkg::rb_addr;
                    end
                end
                mem_bridge_pkg::rb_addr: begin
                    beat_cnt <= '0;
                    if (mem_ar_ready) begin
                        state <= mem_bridge_pkg::rb_beats;
                    end
                end
                mem_bridge_pkg::rb_beats: begin
                    if (mem_r_valid) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (mem_r_last) begin
                            state <= mem_bridge_pkg::rb_hold;
                        end
                    end
                end
                mem_bridge_pkg::rb_hold: begin
                    // line stays put until the l2 takes it
                    if (ret.rdy) begin
                        state <= mem_bridge_pkg::rb_idle;
                    end
                end
                default: state <= mem_bridge_pkg::rb_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == mem_bridge_pkg::rb_idle && ret.req) begin
            addr_q <= ret.addr;
            len_q  <= ret.rlen;
        end
        // beat i lands in word i from the bottom
        if (state == mem_bridge_pkg::rb_beats && mem_r_valid) begin
            line_q[beat_cnt*32 +: 32] <= mem_r_data;
        end
    end

    assign mem_ar_valid = (state == mem_bridge_pkg::rb_addr);
    assign mem_ar_addr  = addr_q;
    assign mem_ar_len   = len_q;
    assign ret.addr_ok  = mem_ar_valid && mem_ar_ready;
    assign ret.data_ok  = (state == mem_bridge_pkg::rb_hold);
    assign ret.data     = line_q;

endmodule

// File: verilog/write_buffer.sv
// ----------------------------------------
// dirty line write buffer
// ----------------------------------------
module write_buffer #(
    parameter int offset_width = 2,
    parameter int wb_depth     = 4
) (
    input  logic                                 clk,
    input  logic                                 rstn,
    input  logic                                 wr_valid,
    input  mem_bridge_pkg::addr_t                wr_addr,
    input  logic [32*(1<<offset_width)-1:0]      wr_data,
    output logic                                 full,
    input  mem_bridge_pkg::addr_t                query_addr,
    output logic                                 query_ok,
    output logic [32*(1<<offset_width)-1:0]      query_data,
    output logic                                 mem_wr_valid,
    output mem_bridge_pkg::addr_t                mem_wr_addr,
    output logic [32*(1<<offset_width)-1:0]      mem_wr_data,
    input  logic                                 mem_wr_ack
);
    localparam int line_w = 32 * (1 << offset_width);
    localparam int ptr_w  = (wb_depth > 1) ? $clog2(wb_depth) : 1;

    mem_bridge_pkg::addr_t addr_q [wb_depth];
    logic [line_w-1:0]     data_q [wb_depth];
    logic [wb_depth-1:0]   valid;
    logic [ptr_w-1:0]      head;
    logic [ptr_w-1:0]      tail;
    logic                  wr_hit;
    logic [ptr_w-1:0]      wr_idx;

    // lookups against the valid entries
    always_comb begin
        query_ok   = 1'b0;
        query_data = '0;
        wr_hit     = 1'b0;
        wr_idx     = '0;
        for (int i = 0; i < wb_depth; i++) begin
            if (valid[i] && addr_q[i] == query_addr) begin
                query_ok   = 1'b1;
                query_data = data_q[i];
            end
            // an entry retiring this cycle cannot take the update
            if (valid[i] && addr_q[i] == wr_addr &&
                !(mem_wr_ack && head == ptr_w'(i))) begin
                wr_hit = 1'b1;
                wr_idx = ptr_w'(i);
            end
        end
    end

    assign full         = &valid;
    assign mem_wr_valid = valid[head];
    assign mem_wr_addr  = addr_q[head];
    assign mem_wr_data  = data_q[head];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid <= '0;
            head  <= '0;
            tail  <= '0;
        end else begin
            if (mem_wr_ack && valid[head]) begin
                valid[head] <= 1'b0;
                head        <= (head == ptr_w'(wb_depth - 1)) ? '0 : head + 1'b1;
            end
            if (wr_valid && !wr_hit && !full) begin
                valid[tail] <= 1'b1;
                tail        <= (tail == ptr_w'(wb_depth - 1)) ? '0 : tail + 1'b1;
            end
        end
    end

    // entry payload is rewritten in place on a hit
    always_ff @(posedge clk) begin
        if (wr_valid && wr_hit) begin
            data_q[wr_idx] <= wr_data;
        end else if (wr_valid && !full) begin
            addr_q[tail] <= wr_addr;
            data_q[tail] <= wr_data;
        end
    end

endmodule
